// ==== list.f ====
+incdir+hdl
hdl/txn_pkg.sv
hdl/perf_pkg.sv
hdl/dependency_checker.sv
hdl/batch_tracker.sv
hdl/schedule_control.sv
hdl/perf_counters.sv
hdl/conflict_checker.sv
bench/tb_conflict_checker.sv

// ==== Bender.yml ====
package:
  name: conflict_checker

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/txn_pkg.sv
      - hdl/perf_pkg.sv
      - hdl/dependency_checker.sv
      - hdl/batch_tracker.sv
      - hdl/schedule_control.sv
      - hdl/perf_counters.sv
      - hdl/conflict_checker.sv
  - target: test
    files:
      - bench/tb_conflict_checker.sv

// ==== bench/tb_conflict_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conflict_consts.svh"

module tb_conflict_checker;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    // Upper bound on transactions over all tests, 20 cycles each
    localparam int TXN_BUDGET   = 70;
    localparam int WATCHDOG_NS  = (TXN_BUDGET * 20 + RESET_CYCLES + 100) * CLK_PERIOD;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  s_valid;
    logic                  s_ready;
    txn_pkg::txn_t         s_txn;
    logic                  m_valid;
    logic                  m_ready;
    txn_pkg::txn_t         m_txn;
    logic                  batch_completed;
    perf_pkg::perf_stats_t stats;

    // Reference model of the batch sets and counters
    txn_pkg::dep_vec_t     model_reads;
    txn_pkg::dep_vec_t     model_writes;
    perf_pkg::perf_stats_t model_stats;

    logic [15:0] lfsr_state = 16'd15;
    int          err_count;
    int          test_errs_start;
    int          tests_passed;
    int          tests_failed;

    conflict_checker i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .s_valid         (s_valid),
        .s_ready         (s_ready),
        .s_txn           (s_txn),
        .m_valid         (m_valid),
        .m_ready         (m_ready),
        .m_txn           (m_txn),
        .batch_completed (batch_completed),
        .stats           (stats)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[62:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic txn_pkg::dep_vec_t one_hot(input int b);
        txn_pkg::dep_vec_t v;
        v = '0;
        v[b] = 1'b1;
        return v;
    endfunction

    // One to four random resources, so conflicts stay occasional
    function automatic txn_pkg::dep_vec_t sparse_vec();
        txn_pkg::dep_vec_t v;
        int                count;
        int                i;
        v = '0;
        count = int'(rand_bits(2)) + 1;
        for (i = 0; i < count; i++) begin
            v = v | one_hot(int'(rand_bits(8)));
        end
        return v;
    endfunction

    function automatic txn_pkg::txn_t make_txn(input logic [63:0] owner,
                                               input txn_pkg::dep_vec_t rd,
                                               input txn_pkg::dep_vec_t wr);
        txn_pkg::txn_t t;
        t.owner      = owner;
        t.read_deps  = rd;
        t.write_deps = wr;
        return t;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic value_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic plain_failure(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    task automatic compare_stats(input string ctx);
        if (stats !== model_stats) begin
            value_error($sformatf(
                "%s: raw/waw/war/filter/done %0d/%0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d/%0d",
                ctx, stats.raw_conflicts, stats.waw_conflicts, stats.war_conflicts,
                stats.filter_hits, stats.transactions_processed,
                model_stats.raw_conflicts, model_stats.waw_conflicts,
                model_stats.war_conflicts, model_stats.filter_hits,
                model_stats.transactions_processed));
        end
    endtask

    // Send one transaction, hold m_ready low for stall cycles once m_valid rises
    task automatic process_txn(input txn_pkg::txn_t t, input int stall, input string ctx);
        logic raw;
        logic waw;
        logic war;
        logic reject;
        int   waited;
        int   i;
        raw    = |(t.read_deps & model_writes);
        waw    = |(t.write_deps & model_writes);
        war    = |(t.write_deps & model_reads);
        reject = raw | waw | war;
        s_valid = 1'b1;
        s_txn   = t;
        waited  = 0;
        while (!s_ready && waited < 20) begin
            step();
            waited++;
        end
        if (!s_ready) begin
            plain_failure({ctx, ": the DUT never accepted the transaction"});
            s_valid = 1'b0;
            return;
        end
        step();
        s_valid = 1'b0;
        s_txn   = '0;
        // Conflict counters move one edge after acceptance
        model_stats.raw_conflicts = model_stats.raw_conflicts + raw;
        model_stats.waw_conflicts = model_stats.waw_conflicts + waw;
        model_stats.war_conflicts = model_stats.war_conflicts + war;
        model_stats.filter_hits   = model_stats.filter_hits + reject;
        waited = 0;
        while (!m_valid && !s_ready && waited < 10) begin
            step();
            waited++;
        end
        if (m_valid) begin
            if (reject) begin
                value_error({ctx, ": conflicting transaction appeared on the output"});
            end
            if (waited != 2) begin
                value_error($sformatf("%s: m_valid after %0d cycles, expected 2", ctx, waited));
            end
            for (i = 0; i < stall; i++) begin
                if (!m_valid || m_txn !== t || s_ready) begin
                    value_error({ctx, ": output not held under back-pressure"});
                end
                compare_stats({ctx, " stall"});
                step();
            end
            m_ready = 1'b1;
            if (!m_valid || m_txn !== t) begin
                value_error({ctx, ": forwarded transaction differs from the input"});
            end
            step();
            m_ready = 1'b0;
            if (m_valid) begin
                value_error({ctx, ": m_valid still high after the handshake"});
            end
            model_reads  = model_reads | t.read_deps;
            model_writes = model_writes | t.write_deps;
            step();
            if (!s_ready) begin
                value_error({ctx, ": s_ready not back one cycle after the handshake"});
            end
        end else if (!s_ready) begin
            plain_failure({ctx, ": the DUT neither forwarded nor finished the transaction"});
            return;
        end else begin
            if (!reject) begin
                plain_failure({ctx, ": a clean transaction was dropped"});
            end else if (waited != 3) begin
                value_error($sformatf("%s: s_ready back after %0d cycles, expected 3",
                                      ctx, waited));
            end
        end
        waited = 0;
        while (!s_ready && waited < 10) begin
            step();
            waited++;
        end
        if (!s_ready) begin
            plain_failure({ctx, ": the DUT did not return to idle"});
            return;
        end
        model_stats.transactions_processed = model_stats.transactions_processed + 1;
        compare_stats(ctx);
    endtask

    // Pulse batch end while the DUT is idle
    task automatic end_batch();
        batch_completed = 1'b1;
        step();
        batch_completed = 1'b0;
        model_reads  = '0;
        model_writes = '0;
        model_stats.transactions_processed = '0;
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_errs_start) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, err_count - test_errs_start);
            tests_failed++;
        end
        test_errs_start = err_count;
    endtask

    task automatic test_reset();
        if (!s_ready || m_valid) begin
            value_error("s_ready or m_valid wrong after reset");
        end
        compare_stats("reset");
        finish_test("reset");
    endtask

    task automatic test_clean();
        int i;
        for (i = 0; i < 6; i++) begin
            process_txn(make_txn(64'h100 + i, one_hot(3 + i * 37), one_hot(20 + i * 37)),
                        0, $sformatf("clean %0d", i));
        end
        finish_test("clean forwarding");
    endtask

    // Reject one transaction and check the counter deltas it caused
    task automatic expect_reject(input txn_pkg::txn_t t, input logic [3:0] exp,
                                 input string ctx);
        perf_pkg::perf_stats_t prev_stats;
        logic [3:0]            delta;
        prev_stats = stats;
        process_txn(t, 0, ctx);
        delta = {stats.raw_conflicts[0] ^ prev_stats.raw_conflicts[0],
                 stats.waw_conflicts[0] ^ prev_stats.waw_conflicts[0],
                 stats.war_conflicts[0] ^ prev_stats.war_conflicts[0],
                 stats.filter_hits[0] ^ prev_stats.filter_hits[0]};
        if (delta !== exp) begin
            value_error($sformatf("%s: raw/waw/war/filter steps %b, expected %b",
                                  ctx, delta, exp));
        end
    endtask

    task automatic test_conflicts();
        process_txn(make_txn(64'h200, one_hot(64), one_hot(63) | one_hot(255)), 0, "setup");
        expect_reject(make_txn(64'h201, one_hot(63), '0), 4'b1001, "raw only");
        expect_reject(make_txn(64'h202, '0, one_hot(255)), 4'b0101, "waw only");
        expect_reject(make_txn(64'h203, '0, one_hot(64)), 4'b0011, "war only");
        expect_reject(make_txn(64'h204, one_hot(255), one_hot(63) | one_hot(64)),
                      4'b1111, "all three");
        finish_test("conflict filtering");
    endtask

    task automatic test_backpressure();
        process_txn(make_txn(64'h300, one_hot(100), one_hot(101)),
                    int'(rand_bits(3)) + 4, "stalled");
        process_txn(make_txn(64'h301, '0, one_hot(100)), 0, "after stall war");
        process_txn(make_txn(64'h302, one_hot(101), '0), 0, "after stall raw");
        finish_test("back-pressure");
    endtask

    task automatic test_batch_end();
        end_batch();
        compare_stats("batch end");
        process_txn(make_txn(64'h400, one_hot(255), one_hot(63)), 0, "new batch");
        finish_test("batch end");
    endtask

    task automatic test_random();
        int i;
        for (i = 0; i < 40; i++) begin
            if (rand_bits(3) == 0) begin
                end_batch();
            end
            process_txn(make_txn(rand_bits(64), sparse_vec(), sparse_vec()),
                        int'(rand_bits(3)), $sformatf("random %0d", i));
        end
        finish_test("random stream");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst_n           = 1'b0;
        s_valid         = 1'b0;
        s_txn           = '0;
        m_ready         = 1'b0;
        batch_completed = 1'b0;
        model_reads     = '0;
        model_writes    = '0;
        model_stats     = '0;
        err_count       = 0;
        test_errs_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step();
        test_reset();
        test_clean();
        test_conflicts();
        test_backpressure();
        test_batch_end();
        test_random();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/conflict_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module conflict_checker (
    input  wire                   clk,
    input  wire                   rst_n,

    // Input stream
    input  wire                   s_valid,
    output logic                  s_ready,
    input  wire txn_pkg::txn_t    s_txn,

    // Output stream, clean transactions only
    output logic                  m_valid,
    input  wire                   m_ready,
    output txn_pkg::txn_t         m_txn,

    input  wire                   batch_completed,
    output perf_pkg::perf_stats_t stats
);

    txn_pkg::txn_t      cur_txn;
    txn_pkg::dep_vec_t  batch_reads;
    txn_pkg::dep_vec_t  batch_writes;
    txn_pkg::conflict_t conflicts;
    logic               check_pulse;
    logic               merge_pulse;
    logic               done_pulse;

    schedule_control i_sched (
        .clk         (clk),
        .rst_n       (rst_n),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .s_txn       (s_txn),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .m_txn       (m_txn),
        .cur_txn     (cur_txn),
        .conflicts   (conflicts),
        .check_pulse (check_pulse),
        .merge_pulse (merge_pulse),
        .done_pulse  (done_pulse)
    );

    dependency_checker i_dep (
        .cur_txn      (cur_txn),
        .batch_reads  (batch_reads),
        .batch_writes (batch_writes),
        .conflicts    (conflicts)
    );

    batch_tracker i_batch (
        .clk             (clk),
        .rst_n           (rst_n),
        .cur_txn         (cur_txn),
        .merge_pulse     (merge_pulse),
        .batch_completed (batch_completed),
        .batch_reads     (batch_reads),
        .batch_writes    (batch_writes)
    );

    perf_counters i_perf (
        .clk             (clk),
        .rst_n           (rst_n),
        .check_pulse     (check_pulse),
        .done_pulse      (done_pulse),
        .conflicts       (conflicts),
        .batch_completed (batch_completed),
        .stats           (stats)
    );

endmodule

`default_nettype wire

// ==== hdl/perf_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conflict_consts.svh"

module perf_counters (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     check_pulse,
    input  wire                     done_pulse,
    input  wire txn_pkg::conflict_t conflicts,
    input  wire                     batch_completed,
    output perf_pkg::perf_stats_t   stats
);

    logic any_conflict;

    assign any_conflict = conflicts.raw | conflicts.waw | conflicts.war;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stats <= '0;
        end else begin
            // One transaction may bump several hazard counters at once
            if (check_pulse) begin
                stats.raw_conflicts <= stats.raw_conflicts +
                                       perf_pkg::count_t'(conflicts.raw);
                stats.waw_conflicts <= stats.waw_conflicts +
                                       perf_pkg::count_t'(conflicts.waw);
                stats.war_conflicts <= stats.war_conflicts +
                                       perf_pkg::count_t'(conflicts.war);
                // but it is filtered only once
                stats.filter_hits   <= stats.filter_hits +
                                       perf_pkg::count_t'(any_conflict);
            end

            // Throughput restarts with each batch, clear beats a retire
            if (batch_completed) begin
                stats.transactions_processed <= '0;
            end else if (done_pulse) begin
                stats.transactions_processed <= stats.transactions_processed +
                                                `CC_COUNT_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/schedule_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module schedule_control (
    input  wire                     clk,
    input  wire                     rst_n,

    // Input stream
    input  wire                     s_valid,
    output logic                    s_ready,
    input  wire txn_pkg::txn_t      s_txn,

    // Output stream
    output logic                    m_valid,
    input  wire                     m_ready,
    output txn_pkg::txn_t           m_txn,

    // Checker interface
    output txn_pkg::txn_t           cur_txn,
    input  wire txn_pkg::conflict_t conflicts,

    // Event pulses
    output logic                    check_pulse,
    output logic                    merge_pulse,
    output logic                    done_pulse
);

    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        OUTPUT,
        COMPLETE
    } state_t;

    state_t             state;
    txn_pkg::conflict_t verdict;
    logic               verdict_valid;
    logic               reject;

    // Only one transaction in flight, so input is taken only when idle
    assign s_ready = (state == IDLE);

    // Held in cur_txn until the transaction retires
    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            cur_txn <= s_txn;
        end
    end

    assign reject = verdict.raw | verdict.waw | verdict.war;

    // CHECK spends two cycles: sample the checker, then act on it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            verdict       <= '0;
            verdict_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (s_valid) begin
                        state <= CHECK;
                    end
                end

                CHECK: begin
                    if (!verdict_valid) begin
                        verdict       <= conflicts;
                        verdict_valid <= 1'b1;
                    end else begin
                        verdict_valid <= 1'b0;
                        // Rejected transactions skip the output stage
                        state <= reject ? COMPLETE : OUTPUT;
                    end
                end

                OUTPUT: begin
                    if (m_ready) begin
                        state <= COMPLETE;
                    end
                end

                COMPLETE: begin
                    state <= IDLE;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Output stage, stable while waiting on m_ready
    assign m_valid = (state == OUTPUT);
    assign m_txn   = cur_txn;

    // First CHECK cycle is when the verdict is sampled
    assign check_pulse = (state == CHECK) && !verdict_valid;

    // Footprint joins the batch only once the handshake happens
    assign merge_pulse = m_valid && m_ready;

    assign done_pulse = (state == COMPLETE);

endmodule

`default_nettype wire

// ==== hdl/batch_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conflict_consts.svh"

module batch_tracker (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire txn_pkg::txn_t     cur_txn,
    input  wire                    merge_pulse,
    input  wire                    batch_completed,
    output txn_pkg::dep_vec_t      batch_reads,
    output txn_pkg::dep_vec_t      batch_writes
);

    // Union of the footprints of everything forwarded in this batch.
    // An empty set never conflicts, so the first transaction always passes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            batch_reads  <= {`CC_MAX_DEPS{1'b0}};
            batch_writes <= {`CC_MAX_DEPS{1'b0}};
        end else if (batch_completed) begin
            // Batch end takes priority over a merge in the same cycle
            batch_reads  <= {`CC_MAX_DEPS{1'b0}};
            batch_writes <= {`CC_MAX_DEPS{1'b0}};
        end else if (merge_pulse) begin
            batch_reads  <= batch_reads | cur_txn.read_deps;
            batch_writes <= batch_writes | cur_txn.write_deps;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dependency_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conflict_consts.svh"

module dependency_checker (
    input  wire txn_pkg::txn_t     cur_txn,
    input  wire txn_pkg::dep_vec_t batch_reads,
    input  wire txn_pkg::dep_vec_t batch_writes,
    output txn_pkg::conflict_t     conflicts
);

    logic [`CC_NUM_CHUNKS-1:0] raw_chunk;
    logic [`CC_NUM_CHUNKS-1:0] waw_chunk;
    logic [`CC_NUM_CHUNKS-1:0] war_chunk;

    // Each chunk checks its own slice of both vectors in parallel
    generate
        for (genvar i = 0; i < `CC_NUM_CHUNKS; i++) begin : g_chunk
            localparam int LO = i * `CC_CHUNK_SIZE;

            // Read of a resource the batch already writes
            assign raw_chunk[i] = |(cur_txn.read_deps[LO +: `CC_CHUNK_SIZE] &
                                    batch_writes[LO +: `CC_CHUNK_SIZE]);

            // Second writer to the same resource
            assign waw_chunk[i] = |(cur_txn.write_deps[LO +: `CC_CHUNK_SIZE] &
                                    batch_writes[LO +: `CC_CHUNK_SIZE]);

            // Write to a resource the batch still reads
            assign war_chunk[i] = |(cur_txn.write_deps[LO +: `CC_CHUNK_SIZE] &
                                    batch_reads[LO +: `CC_CHUNK_SIZE]);
        end
    endgenerate

    // Any chunk hit flags the whole transaction
    assign conflicts = '{
        raw: |raw_chunk,
        waw: |waw_chunk,
        war: |war_chunk
    };

endmodule

`default_nettype wire

// ==== hdl/perf_pkg.sv ====
`default_nettype none

`include "conflict_consts.svh"

package perf_pkg;

    typedef logic [`CC_COUNT_W-1:0] count_t;

    // Conflict and filter counts run across batches
    // transactions_processed restarts with every batch
    typedef struct packed {
        count_t raw_conflicts;
        count_t waw_conflicts;
        count_t war_conflicts;
        count_t filter_hits;
        count_t transactions_processed;
    } perf_stats_t;

endpackage

`default_nettype wire

// ==== hdl/txn_pkg.sv ====
`default_nettype none

`include "conflict_consts.svh"

package txn_pkg;

    // Read or write footprint of a transaction, one bit per resource
    typedef logic [`CC_MAX_DEPS-1:0] dep_vec_t;

    // Program that issued the transaction
    typedef logic [`CC_OWNER_W-1:0] owner_id_t;

    typedef struct packed {
        owner_id_t owner;
        dep_vec_t  read_deps;
        dep_vec_t  write_deps;
    } txn_t;

    // Hazard flags against the current batch
    typedef struct packed {
        logic raw;
        logic waw;
        logic war;
    } conflict_t;

endpackage

`default_nettype wire

// ==== hdl/conflict_consts.svh ====
`ifndef CONFLICT_CONSTS_SVH
`define CONFLICT_CONSTS_SVH

// One bit per tracked resource
`define CC_MAX_DEPS 256

// Bits compared by each parallel chunk checker
`define CC_CHUNK_SIZE 64
`define CC_NUM_CHUNKS (`CC_MAX_DEPS / `CC_CHUNK_SIZE)

`define CC_OWNER_W 64
`define CC_COUNT_W 32

`endif
